/* all.f */
common/busPkg.sv
common/psgPkg.sv
channel/waveChannel.sv
verilog/busArbiter.sv
verilog/waveFetchEngine.sv
verilog/waveMixer.sv
verilog/psgWaveTop.sv
dv/waveMemModel.sv
dv/psgTb.sv

/* channel/waveChannel.sv */
module waveChannel (
	input logic clk,
	input logic rst,
	input logic ce,
	input logic regWe,
	input logic regSel,
	input psgPkg::chanRegWord_u regData,
	input logic sel,
	input logic rdStrobe,
	input logic [busPkg::MemDataW-1:0] rdData,
	output logic req,
	output logic [busPkg::MemAddrW-1:0] addr,
	output logic signed [psgPkg::ScaledW-1:0] scaled
);
	import psgPkg::*;
	import busPkg::*;

	logic [RegWordW-1:0] freq;
	logic [VolumeW-1:0] volume;
	logic [TableBaseW-1:0] tableBase;
	logic [PhaseW-1:0] phase;
	logic [IndexW-1:0] index;
	logic [IndexW-1:0] lastIndex;
	logic signed [SampleW-1:0] sample;
	logic signed [SampleW+VolumeW:0] product;

	// ========================================
	// register writes
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			freq <= '0;
			volume <= '0;
			tableBase <= '0;
		end else if (regWe) begin
			if (regSel) begin
				volume <= regData.waveView.volume;
				tableBase <= regData.waveView.tableBase;
			end else begin
				freq <= regData.freqView;
			end
		end
	end

	// ========================================
	// phase and sample request
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= '0;
		end else if (ce) begin
			phase <= phase + PhaseW'(freq);
		end
	end

	assign index = phase[PhaseW-1 -: IndexW];

	// a new sample is wanted whenever the index has moved past the one held
	assign req = index != lastIndex;
	assign addr = {tableBase, index};

	// only the bus owner takes the returned byte
	always_ff @(posedge clk) begin
		if (rst) begin
			lastIndex <= '0;
			sample <= '0;
		end else if (sel && rdStrobe) begin
			lastIndex <= index;
			sample <= rdData;
		end
	end

	// ========================================
	// volume scaling
	// ========================================

	// volume is unsigned, so it gets a zero sign bit before the multiply
	assign product = sample * $signed({1'b0, volume});

	always_ff @(posedge clk) begin
		if (rst) begin
			scaled <= '0;
		end else begin
			scaled <= ScaledW'(product >>> VolumeW);
		end
	end

endmodule

/* common/busPkg.sv */
package busPkg;

	// ========================================
	// wave memory bus
	// ========================================

	// byte-wide wave memory, 64K samples
	localparam int MemAddrW = 16;
	localparam int MemDataW = 8;

	// a wave table address is {table base, sample index}
	// the base picks one of 1024 tables of 64 samples each
	localparam int TableBaseW = 10;

endpackage

/* common/psgPkg.sv */
package psgPkg;

	// ========================================
	// channel geometry
	// ========================================

	localparam int NumChannels = 8;
	localparam int ChanW = $clog2(NumChannels);

	// phase accumulator, the top IndexW bits select the sample
	localparam int PhaseW = 22;
	localparam int IndexW = 6;

	// ========================================
	// sample path
	// ========================================

	localparam int SampleW = 8;
	localparam int VolumeW = 4;
	// sample times volume, shifted back down by VolumeW
	localparam int ScaledW = 8;
	// headroom for adding all channels
	localparam int MixW = ScaledW + ChanW;

	// ========================================
	// channel register word
	// ========================================

	localparam int RegWordW = 16;
	localparam int SpareW = RegWordW - VolumeW - busPkg::TableBaseW;

	typedef struct packed {
		logic [VolumeW-1:0] volume;
		logic [SpareW-1:0] spare;
		logic [busPkg::TableBaseW-1:0] tableBase;
	} waveWord_s;

	// regSel 0 writes a phase increment, regSel 1 writes volume and table base
	typedef union packed {
		logic [RegWordW-1:0] freqView;
		waveWord_s waveView;
	} chanRegWord_u;

endpackage

/* dv/psgTb.sv */
module psgTb;
	timeunit 1ns;
	timeprecision 1ps;
	import psgPkg::*;
	import busPkg::*;

	logic clk, rst, ce, regWe, regSel, memRdValid, memReq;
	logic [ChanW-1:0] regChan;
	logic [ChanW-1:0] memChan;
	chanRegWord_u regData;
	logic [MemDataW-1:0] memRdData;
	logic [MemAddrW-1:0] memAddr;
	logic signed [MixW-1:0] mixOut;
	logic signed [MixW-1:0] snapMix;

	integer seed;
	int cycleNo, cePulses, readCount, errors, testErrors, testsRun, testsFailed;
	int baseErrors, overlapErrors, waitCycles, quietCycles, lastCount, startReads;
	int snapReads, expected, sampleVal, seenBad;
	int progBase[NumChannels];
	int progVol[NumChannels];
	int lastAddr[NumChannels];
	bit lastValid[NumChannels];
	int chanLog[$];
	bit outstanding, ceEnable;

	psgWaveTop i_psgWaveTop (.clk(clk), .rst(rst), .ce(ce), .regWe(regWe), .regChan(regChan),
		.regSel(regSel), .regData(regData), .memRdValid(memRdValid), .memRdData(memRdData),
		.memReq(memReq), .memAddr(memAddr), .memChan(memChan), .mixOut(mixOut));

	waveMemModel i_waveMemModel (.clk(clk), .rst(rst), .memReq(memReq), .memAddr(memAddr),
		.memRdValid(memRdValid), .memRdData(memRdData));

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ========================================
	// bus monitor
	// ========================================

	always @(posedge clk) begin
		if (rst) begin
			outstanding = 1'b0;
		end else begin
			if (memRdValid) outstanding = 1'b0;
			if (memReq) begin
				if (outstanding) begin
					$display("Error: memReq for channel %0d while a read is still open", memChan);
					overlapErrors++;
					errors++;
				end
				if (int'(memAddr[MemAddrW-1 -: TableBaseW]) != progBase[memChan]) begin
					$display("Fail addressOwner: channel %0d expected base %0d, actual %0d",
						memChan, progBase[memChan], memAddr[MemAddrW-1 -: TableBaseW]);
					baseErrors++;
					errors++;
				end
				outstanding = 1'b1;
				lastAddr[memChan] = int'(memAddr);
				lastValid[memChan] = 1'b1;
				chanLog.push_back(int'(memChan));
				readCount++;
			end
		end
	end

	// ========================================
	// helpers
	// ========================================

	// one cycle, inputs change on the falling edge, ce one cycle in four
	task tick();
		@(negedge clk);
		cycleNo++;
		regWe = 1'b0;
		ce = ceEnable && (cycleNo % 4 == 0);
		if (ce) cePulses++;
	endtask

	task writeReg(input int ch, input logic sel, input chanRegWord_u word);
		tick();
		regWe = 1'b1;
		regChan = ChanW'(ch);
		regSel = sel;
		regData = word;
	endtask

	task programWave(input int ch, input int base, input int vol);
		chanRegWord_u w;
		w.waveView.volume = VolumeW'(vol);
		w.waveView.spare = '0;
		w.waveView.tableBase = TableBaseW'(base);
		progBase[ch] = base;
		progVol[ch] = vol;
		writeReg(ch, 1'b1, w);
	endtask

	task programFreq(input int ch, input int freq);
		chanRegWord_u w;
		w.freqView = RegWordW'(freq);
		writeReg(ch, 1'b0, w);
	endtask

	task reportFail(input string name, input int exp, input int act);
		$display("Fail %s: expected %0d, actual %0d", name, exp, act);
		testErrors++;
		errors++;
	endtask

	task finishTest(input string name, input int failures);
		testsRun++;
		if (failures == 0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, failures);
			testsFailed++;
		end
		testErrors = 0;
	endtask

	task timeoutFail(input string what);
		$display("Error: timed out waiting for %s", what);
		$display("FAIL: see errors above");
		$finish;
	endtask

	// reset held for 8 cycles with ce running, outputs must stay quiet throughout
	// ce is left low afterwards
	task applyReset(input string name);
		rst = 1'b1;
		ceEnable = 1'b1;
		for (int ch = 0; ch < NumChannels; ch++) begin
			progBase[ch] = 0;
			progVol[ch] = 0;
			lastValid[ch] = 1'b0;
		end
		tick();
		repeat (7) begin
			@(posedge clk);
			if (memReq !== 1'b0) reportFail(name, 0, int'(memReq));
			if (mixOut !== '0) reportFail(name, 0, int'(mixOut));
			tick();
		end
		rst = 1'b0;
		ceEnable = 1'b0;
	endtask

	// ========================================
	// test sequence
	// ========================================

	initial begin
		seed = 32'h2bb4_0d2f;
		{rst, ce, regWe, regSel, ceEnable} = 5'b10000;
		regChan = '0;
		regData = '0;
		{cycleNo, cePulses, readCount, errors, testErrors, testsRun, testsFailed} = '0;
		baseErrors = 0;
		overlapErrors = 0;

		// all phases sit at index 0, so nothing may request even with ce running
		applyReset("resetState");
		ceEnable = 1'b1;
		repeat (4) begin
			@(posedge clk);
			if (memReq !== 1'b0) reportFail("resetState", 0, int'(memReq));
			if (mixOut !== '0) reportFail("resetState", 0, int'(mixOut));
			tick();
		end
		finishTest("resetState", testErrors);

		// bases first so that no read can see a stale base
		ceEnable = 1'b1;
		for (int ch = 0; ch < NumChannels; ch++) begin
			programWave(ch, $random(seed) & 1023, $random(seed) & 15);
		end
		for (int ch = 0; ch < NumChannels; ch++) begin
			programFreq(ch, 16'h0800 | ($random(seed) & 16'h07ff));
		end
		startReads = readCount;
		repeat (3000) tick();
		if (readCount - startReads < 16) begin
			$display("Error: only %0d memory reads seen in addressOwner", readCount - startReads);
			testErrors++;
			errors++;
		end
		finishTest("addressOwner", testErrors + baseErrors);

		// two enabled steps of 0x8000 move every index from 0 to 1
		applyReset("priorityOrder");
		for (int ch = 0; ch < NumChannels; ch++) begin
			programWave(ch, $random(seed) & 1023, 8 + ($random(seed) & 7));
		end
		for (int ch = 0; ch < NumChannels; ch++) programFreq(ch, 16'h8000);
		cePulses = 0;
		ceEnable = 1'b1;
		waitCycles = 0;
		while (cePulses < 2) begin
			tick();
			waitCycles++;
			if (waitCycles > 20) timeoutFail("two clock enable pulses");
		end
		ceEnable = 1'b0;
		for (int ch = 0; ch < NumChannels; ch++) programFreq(ch, 0);
		chanLog.delete();
		ceEnable = 1'b1;
		waitCycles = 0;
		while (chanLog.size() < NumChannels) begin
			tick();
			waitCycles++;
			if (waitCycles > 1000) timeoutFail("eight reads in priority order");
		end
		for (int i = 0; i < NumChannels; i++) begin
			if (chanLog[i] != i) reportFail("priorityOrder", i, chanLog[i]);
			// every channel fetches sample index 1
			if (lastAddr[i] % (1 << IndexW) != 1) begin
				reportFail("priorityOrder", 1, lastAddr[i] % (1 << IndexW));
			end
		end
		finishTest("priorityOrder", testErrors);

		// frequencies are already 0, wait for the bus to settle
		quietCycles = 0;
		waitCycles = 0;
		lastCount = readCount;
		while (quietCycles < 32) begin
			tick();
			waitCycles++;
			if (outstanding || readCount != lastCount) quietCycles = 0;
			else quietCycles++;
			lastCount = readCount;
			if (waitCycles > 2000) timeoutFail("a quiet bus");
		end
		expected = 0;
		for (int ch = 0; ch < NumChannels; ch++) begin
			if (lastValid[ch]) begin
				sampleVal = $signed(i_waveMemModel.mem[lastAddr[ch]]);
				expected += (sampleVal * progVol[ch]) >>> 4;
			end
		end
		if (int'(mixOut) != expected) reportFail("mixerSum", expected, int'(mixOut));
		finishTest("mixerSum", testErrors);

		// get reads going again, then drop ce and let the last one land
		for (int ch = 0; ch < NumChannels; ch++) begin
			programFreq(ch, 16'h0800 | ($random(seed) & 16'h07ff));
		end
		repeat (400) tick();
		ceEnable = 1'b0;
		tick();
		waitCycles = 0;
		while (outstanding) begin
			tick();
			waitCycles++;
			if (waitCycles > 100) timeoutFail("the last read before the freeze");
		end
		repeat (4) tick();
		snapMix = mixOut;
		snapReads = readCount;
		seenBad = 0;
		repeat (200) begin
			tick();
			if (readCount != snapReads && seenBad == 0) begin
				$display("Error: memReq issued while clock enable was held low");
				testErrors++;
				errors++;
				seenBad = 1;
			end
			if (mixOut != snapMix && seenBad == 0) begin
				reportFail("ceFreeze", int'(snapMix), int'(mixOut));
				seenBad = 1;
			end
		end
		finishTest("ceFreeze", testErrors);
		finishTest("oneReadAtATime", overlapErrors);

		$display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

/* dv/waveMemModel.sv */
module waveMemModel (
	input logic clk,
	input logic rst,
	input logic memReq,
	input logic [busPkg::MemAddrW-1:0] memAddr,
	output logic memRdValid,
	output logic [busPkg::MemDataW-1:0] memRdData
);
	timeunit 1ns;
	timeprecision 1ps;
	import busPkg::*;

	localparam int Depth = 1 << MemAddrW;

	logic [MemDataW-1:0] mem [Depth];
	integer seed;
	logic reqSeen;
	logic [MemAddrW-1:0] reqAddr;
	logic [MemAddrW-1:0] readAddr;
	int delay;

	// every sample gets its own random byte
	initial begin
		seed = 32'h2bb4_0d2f;
		for (int a = 0; a < Depth; a++) begin
			mem[a] = MemDataW'($random(seed));
		end
		reqSeen = 1'b0;
		delay = 0;
		memRdValid = 1'b0;
		memRdData = '0;
	end

	always @(posedge clk) begin
		reqSeen <= memReq && !rst;
		reqAddr <= memAddr;
	end

	// answer after 1 to 8 cycles, driven on the falling edge
	always @(negedge clk) begin
		memRdValid = 1'b0;
		if (rst) begin
			delay = 0;
		end else if (reqSeen) begin
			readAddr = reqAddr;
			delay = ($random(seed) & 7) + 1;
		end
		if (delay != 0) begin
			delay = delay - 1;
			if (delay == 0) begin
				memRdValid = 1'b1;
				memRdData = mem[readAddr];
			end
		end
	end

endmodule

/* run.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module psgTb -f all.f -o psgSim || { echo "build failed"; exit 1; }

simOut="$(./obj_dir/psgSim)"
printf '%s\n' "$simOut"

grep -qx "PASS: all tests" <<< "$simOut" && echo "run passed" || { echo "run failed"; exit 1; }

/* verilog/busArbiter.sv */
module busArbiter (
	input logic clk,
	input logic rst,
	input logic ce,
	input logic busFree,
	input logic [psgPkg::NumChannels-1:0] req,
	output logic [psgPkg::NumChannels-1:0] sel,
	output logic [psgPkg::ChanW-1:0] seln
);
	import psgPkg::*;

	logic [NumChannels-1:0] nextSel;
	logic [ChanW-1:0] nextSeln;

	// scan downwards so that the lowest requester is the last one written
	always_comb begin
		nextSel = '0;
		nextSeln = '0;
		for (int i = NumChannels - 1; i >= 0; i--) begin
			if (req[i]) begin
				nextSel = '0;
				nextSel[i] = 1'b1;
				nextSeln = ChanW'(i);
			end
		end
	end

	// ownership moves only when the bus is idle on an enabled cycle
	// with no requester the last owner keeps the bus
	always_ff @(posedge clk) begin
		if (rst) begin
			sel <= '0;
			seln <= '0;
		end else if (ce && busFree && |req) begin
			sel <= nextSel;
			seln <= nextSeln;
		end
	end

	// ========================================
	// checks
	// ========================================

	selOneHot: assert property (
		@(posedge clk) disable iff (rst)
		$onehot0(sel)
	);

	// no change of owner while a read is in flight or the clock is not enabled
	ownerFrozen: assert property (
		@(posedge clk) disable iff (rst)
		!(ce && busFree) |=> $stable(sel) && $stable(seln)
	);

	selnMatch: assert property (
		@(posedge clk) disable iff (rst)
		(sel != '0) |-> (sel == (NumChannels'(1) << seln))
	);

endmodule

/* verilog/psgWaveTop.sv */
module psgWaveTop (
	input logic clk,
	input logic rst,
	input logic ce,
	input logic regWe,
	input logic [psgPkg::ChanW-1:0] regChan,
	input logic regSel,
	input psgPkg::chanRegWord_u regData,
	input logic memRdValid,
	input logic [busPkg::MemDataW-1:0] memRdData,
	output logic memReq,
	output logic [busPkg::MemAddrW-1:0] memAddr,
	output logic [psgPkg::ChanW-1:0] memChan,
	output logic signed [psgPkg::MixW-1:0] mixOut
);
	import psgPkg::*;
	import busPkg::*;

	logic [NumChannels-1:0] chanWe;
	logic [NumChannels-1:0] req;
	logic [NumChannels-1:0] sel;
	logic [ChanW-1:0] seln;
	logic busFree;
	logic rdStrobe;
	logic [MemDataW-1:0] rdData;
	logic [NumChannels*MemAddrW-1:0] chanAddr;
	logic [NumChannels*ScaledW-1:0] scaled;

	// ========================================
	// wave channels
	// ========================================

	for (genvar i = 0; i < NumChannels; i++) begin : chanGen
		// register write reaches only the addressed channel
		assign chanWe[i] = regWe && (regChan == ChanW'(i));

		waveChannel i_waveChannel (
			.clk(clk),
			.rst(rst),
			.ce(ce),
			.regWe(chanWe[i]),
			.regSel(regSel),
			.regData(regData),
			.sel(sel[i]),
			.rdStrobe(rdStrobe),
			.rdData(rdData),
			.req(req[i]),
			.addr(chanAddr[i*MemAddrW +: MemAddrW]),
			.scaled(scaled[i*ScaledW +: ScaledW])
		);
	end

	// ========================================
	// shared bus and output
	// ========================================

	busArbiter i_busArbiter (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.busFree(busFree),
		.req(req),
		.sel(sel),
		.seln(seln)
	);

	waveFetchEngine i_waveFetchEngine (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.sel(sel),
		.seln(seln),
		.req(req),
		.chanAddr(chanAddr),
		.memRdValid(memRdValid),
		.memRdData(memRdData),
		.busFree(busFree),
		.rdStrobe(rdStrobe),
		.rdData(rdData),
		.memReq(memReq),
		.memAddr(memAddr),
		.memChan(memChan)
	);

	waveMixer i_waveMixer (
		.clk(clk),
		.rst(rst),
		.scaledIn(scaled),
		.mixOut(mixOut)
	);

endmodule

/* verilog/waveFetchEngine.sv */
module waveFetchEngine (
	input logic clk,
	input logic rst,
	input logic ce,
	input logic [psgPkg::NumChannels-1:0] sel,
	input logic [psgPkg::ChanW-1:0] seln,
	input logic [psgPkg::NumChannels-1:0] req,
	input logic [psgPkg::NumChannels*busPkg::MemAddrW-1:0] chanAddr,
	input logic memRdValid,
	input logic [busPkg::MemDataW-1:0] memRdData,
	output logic busFree,
	output logic rdStrobe,
	output logic [busPkg::MemDataW-1:0] rdData,
	output logic memReq,
	output logic [busPkg::MemAddrW-1:0] memAddr,
	output logic [psgPkg::ChanW-1:0] memChan
);
	import psgPkg::*;
	import busPkg::*;

	typedef enum logic {
		Idle,
		Busy
	} fetchState_e;

	fetchState_e state;
	logic [NumChannels-1:0] ownedReq;

	// at most one bit survives, the owner's own request
	assign ownedReq = sel & req;

	// ========================================
	// read issue
	// ========================================

	// the owner's request is stale during rdStrobe, it drops at the next edge
	assign memReq = (state == Idle) && ce && |ownedReq && !rdStrobe;
	assign memAddr = chanAddr[seln*MemAddrW +: MemAddrW];
	assign memChan = seln;

	// the issue cycle already counts as taken, so the owner cannot move under it
	assign busFree = (state == Idle) && !memReq;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= Idle;
		end else begin
			case (state)
				Idle: begin
					if (memReq) begin
						state <= Busy;
					end
				end
				Busy: begin
					// latency is open ended, the memory decides
					if (memRdValid) begin
						state <= Idle;
					end
				end
				default: state <= Idle;
			endcase
		end
	end

	// ========================================
	// data return
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			rdStrobe <= 1'b0;
		end else begin
			rdStrobe <= (state == Busy) && memRdValid;
		end
	end

	always_ff @(posedge clk) begin
		if (memRdValid) begin
			rdData <= memRdData;
		end
	end

	// a read keeps the bus taken in the cycle after it is issued
	singleRead: assert property (
		@(posedge clk) disable iff (rst)
		memReq |=> !memReq && !busFree
	);

	strobeAfterValid: assert property (
		@(posedge clk) disable iff (rst)
		rdStrobe |-> $past(memRdValid)
	);

endmodule

/* verilog/waveMixer.sv */
module waveMixer (
	input logic clk,
	input logic rst,
	input logic [psgPkg::NumChannels*psgPkg::ScaledW-1:0] scaledIn,
	output logic signed [psgPkg::MixW-1:0] mixOut
);
	import psgPkg::*;

	logic signed [ScaledW-1:0] sample [NumChannels];
	logic signed [ScaledW:0] pairSum [NumChannels/2];
	logic signed [ScaledW+1:0] quadSum [NumChannels/4];

	// ========================================
	// adder tree
	// ========================================

	// each level grows by one bit, so no level can overflow
	always_comb begin
		for (int i = 0; i < NumChannels; i++) begin
			sample[i] = scaledIn[i*ScaledW +: ScaledW];
		end
		for (int i = 0; i < NumChannels/2; i++) begin
			pairSum[i] = (ScaledW+1)'(sample[2*i]) + (ScaledW+1)'(sample[2*i+1]);
		end
		for (int i = 0; i < NumChannels/4; i++) begin
			quadSum[i] = (ScaledW+2)'(pairSum[2*i]) + (ScaledW+2)'(pairSum[2*i+1]);
		end
	end

	// last add sits right in front of the output register
	always_ff @(posedge clk) begin
		if (rst) begin
			mixOut <= '0;
		end else begin
			mixOut <= MixW'(quadSum[0]) + MixW'(quadSum[1]);
		end
	end

endmodule
